/* all.f */
+incdir+src
src/motion_pkg.sv
src/frame_ram.sv
src/difference_engine.sv
src/scan_counter.sv
src/scan_fsm.sv
src/window_filter.sv
src/centroid_calc.sv
src/motion_top.sv
test/motion_asserts.sv
test/motion_tb.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module motion_tb
output="$(./obj_dir/Vmotion_tb 2>&1)" || true
echo "$output"
grep -qx "Finished with no errors" <<< "$output"

/* test/motion_tb.sv */
`timescale 1ns/1ps
`include "motion_config.svh"

module motion_tb;
	import motion_pkg::*;

	localparam int img_w = `IMAGE_W;
	localparam int img_h = `IMAGE_H;
	localparam int pixels = img_w * img_h;
	localparam int plots = (img_w - 2) * (img_h - 2);
	localparam int scan_limit = 6 * img_w * img_h; // five cycles per column plus margin

	logic     clock;
	logic     rst_n;
	logic     pixel_en;
	coord_x_t pixel_x;
	coord_y_t pixel_y;
	colour_t  pixel_colour;
	logic     vsync_n;
	logic     plot;
	coord_x_t plot_x;
	coord_y_t plot_y;
	logic     plot_colour;
	logic     centroid_valid;
	coord_x_t centroid_x;
	coord_y_t centroid_y;

	colour_t     frame [pixels];      // next frame to send
	colour_t     prev_frame [pixels];
	logic        diff_map [pixels];
	logic        expected_plot [plots]; // eroded image in plot order
	logic [31:0] lfsr_state;
	int          model_cx;
	int          model_cy;
	int          plot_index;
	int          pulses;
	bit          scanning;
	bit          expect_update;
	int          plot_errors;
	int          centroid_errors;
	int          other_errors;
	int          rect_x;
	int          rect_y;
	int          rect_w;
	int          rect_h;

	motion_top dut_i (
		.clock          (clock),
		.rst_n          (rst_n),
		.pixel_en       (pixel_en),
		.pixel_x        (pixel_x),
		.pixel_y        (pixel_y),
		.pixel_colour   (pixel_colour),
		.vsync_n        (vsync_n),
		.plot           (plot),
		.plot_x         (plot_x),
		.plot_y         (plot_y),
		.plot_colour    (plot_colour),
		.centroid_valid (centroid_valid),
		.centroid_x     (centroid_x),
		.centroid_y     (centroid_y)
	);

	always #50 clock = ~clock;

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	function automatic colour_t nonzero_colour();
		int k;
		k = rand_bits(3);
		return (k == 0) ? colour_t'(5) : colour_t'(k);
	endfunction

	task automatic check_plot(input coord_x_t got_x, input coord_x_t exp_x,
		input coord_y_t got_y, input coord_y_t exp_y, input logic got_c, input logic exp_c);
		if (got_x !== exp_x) begin
			plot_errors++;
			$display("mismatch at %0t: plot_x is %0d, expected %0d", $time, got_x, exp_x);
		end
		if (got_y !== exp_y) begin
			plot_errors++;
			$display("mismatch at %0t: plot_y is %0d, expected %0d", $time, got_y, exp_y);
		end
		if (got_c !== exp_c) begin
			plot_errors++;
			$display("mismatch at %0t: plot_colour is %0b, expected %0b", $time, got_c, exp_c);
		end
	endtask

	task automatic check_centroid(input coord_x_t got_x, input coord_x_t exp_x,
		input coord_y_t got_y, input coord_y_t exp_y);
		if (got_x !== exp_x) begin
			centroid_errors++;
			$display("mismatch at %0t: centroid_x is %0d, expected %0d", $time, got_x, exp_x);
		end
		if (got_y !== exp_y) begin
			centroid_errors++;
			$display("mismatch at %0t: centroid_y is %0d, expected %0d", $time, got_y, exp_y);
		end
	endtask

	// one falling edge, outputs are stable here
	task automatic watch_cycle();
		coord_x_t exp_x;
		coord_y_t exp_y;
		@(negedge clock);
		if (plot === 1'b1) begin
			if (!scanning) begin
				other_errors++;
				$display("plot strobe at %0t while no scan was started", $time);
			end else if (plot_index >= plots) begin
				other_errors++;
				$display("extra plot strobe at %0t after the last window position", $time);
			end else begin
				exp_x = coord_x_t'(1 + plot_index % (img_w - 2));
				exp_y = coord_y_t'(1 + plot_index / (img_w - 2));
				check_plot(plot_x, exp_x, plot_y, exp_y, plot_colour, expected_plot[plot_index]);
			end
			plot_index++;
		end
		if (centroid_valid === 1'b1) begin
			pulses++;
			if (!expect_update || pulses > 1) begin
				other_errors++;
				$display("unexpected centroid_valid pulse at %0t", $time);
			end else begin
				check_centroid(centroid_x, coord_x_t'(model_cx), centroid_y, coord_y_t'(model_cy));
			end
		end
	endtask

	task automatic send_frame();
		int a;
		for (int y = 0; y < img_h; y++) begin
			for (int x = 0; x < img_w; x++) begin
				a = y * img_w + x;
				watch_cycle();
				pixel_en = 1'b1;
				pixel_x = coord_x_t'(x);
				pixel_y = coord_y_t'(y);
				pixel_colour = frame[a];
				diff_map[a] = (prev_frame[a] != frame[a]);
				prev_frame[a] = frame[a];
			end
		end
		watch_cycle();
		pixel_en = 1'b0;
		repeat (4) watch_cycle(); // last pixels leave the compare pipeline
	endtask

	task automatic change_frame();
		int x;
		int y;
		rect_x = 10 + rand_bits(7);
		rect_y = 10 + rand_bits(6);
		rect_w = 40 + rand_bits(5);
		rect_h = 30 + rand_bits(5);
		for (y = rect_y; y < rect_y + rect_h; y++) begin
			for (x = rect_x; x < rect_x + rect_w; x++) begin
				frame[y * img_w + x] = frame[y * img_w + x] ^ nonzero_colour();
			end
		end
		// isolated changes, kept off the rectangle
		for (int n = 0; n < 300; n++) begin
			x = rand_bits(9) % img_w;
			y = rand_bits(8) % img_h;
			if (x < rect_x || x >= rect_x + rect_w || y < rect_y || y >= rect_y + rect_h) begin
				frame[y * img_w + x] = frame[y * img_w + x] ^ nonzero_colour();
			end
		end
	endtask

	// erosion of the model map and the centroid it leads to
	task automatic build_expectation(output bit update);
		int count;
		int x_sum;
		int y_sum;
		int idx;
		logic all_set;
		count = 0;
		x_sum = 0;
		y_sum = 0;
		idx = 0;
		for (int py = 1; py < img_h - 1; py++) begin
			for (int px = 1; px < img_w - 1; px++) begin
				all_set = 1'b1;
				for (int dy = -1; dy <= 1; dy++) begin
					for (int dx = -1; dx <= 1; dx++) begin
						all_set = all_set & diff_map[(py + dy) * img_w + px + dx];
					end
				end
				expected_plot[idx] = all_set;
				idx++;
				if (all_set === 1'b1) begin
					count++;
					x_sum += px;
					y_sum += py;
				end
			end
		end
		update = (count >= `DIFF_THRESHOLD);
		if (update) begin
			model_cx = ((model_cx * `BLEND_OLD + ((x_sum / count) % 512) * `BLEND_NEW)
				>> `BLEND_SHIFT) % 512;
			model_cy = ((model_cy * `BLEND_OLD + ((y_sum / count) % 256) * `BLEND_NEW)
				>> `BLEND_SHIFT) % 256;
		end
	endtask

	task automatic run_scan(input bit want_update);
		int cycles;
		bit update;
		build_expectation(update);
		if (update != want_update) begin
			other_errors++;
			$display("test frame does not give the intended centroid decision");
		end
		expect_update = update;
		scanning = 1'b1;
		plot_index = 0;
		pulses = 0;
		watch_cycle();
		vsync_n = 1'b0;
		watch_cycle();
		vsync_n = 1'b1;
		cycles = 0;
		while (plot_index < plots && cycles < scan_limit) begin
			watch_cycle();
			cycles++;
		end
		if (plot_index < plots) begin
			other_errors++;
			$display("scan timed out after %0d of %0d plots", plot_index, plots);
		end
		cycles = 0;
		while (update && pulses == 0 && cycles < 16) begin
			watch_cycle();
			cycles++;
		end
		if (update && pulses == 0) begin
			other_errors++;
			$display("no centroid_valid pulse followed the scan");
		end
		for (cycles = 0; cycles < 8; cycles++) begin
			watch_cycle(); // catches late plots or pulses
		end
		scanning = 1'b0;
		check_centroid(centroid_x, coord_x_t'(model_cx), centroid_y, coord_y_t'(model_cy));
	endtask

	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		pixel_en = 1'b0;
		pixel_x = '0;
		pixel_y = '0;
		pixel_colour = '0;
		vsync_n = 1'b1;
		lfsr_state = 32'h4e8a;
		model_cx = 0;
		model_cy = 0;
		plot_index = 0;
		pulses = 0;
		scanning = 1'b0;
		expect_update = 1'b0;
		plot_errors = 0;
		centroid_errors = 0;
		other_errors = 0;
		repeat (8) watch_cycle();
		rst_n = 1'b1;
		check_centroid(centroid_x, coord_x_t'(0), centroid_y, coord_y_t'(0));

		for (int a = 0; a < pixels; a++) begin
			frame[a] = colour_t'(rand_bits(3));
		end
		send_frame();
		change_frame();
		send_frame();
		run_scan(1'b1);  // first centroid from (0,0)

		change_frame();
		send_frame();
		run_scan(1'b1);  // blends onto the first one

		send_frame();    // same frame again, nothing moved
		run_scan(1'b0);

		$display("plot errors %0d, centroid errors %0d, other errors %0d",
			plot_errors, centroid_errors, other_errors);
		if (plot_errors + centroid_errors + other_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* test/motion_asserts.sv */
`timescale 1ns/1ps
`include "motion_config.svh"

module motion_asserts (
	input logic                 clock,
	input logic                 rst_n,
	input logic                 plot,
	input motion_pkg::coord_x_t plot_x,
	input motion_pkg::coord_y_t plot_y,
	input logic                 centroid_valid
);
	import motion_pkg::*;

	quiet_in_reset: assert property (@(posedge clock) !rst_n |=> (!plot && !centroid_valid))
		else $error("plot or centroid_valid high during reset");

	single_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		centroid_valid |=> !centroid_valid)
		else $error("centroid_valid longer than one cycle");

	// erosion window never reaches the image border
	plot_in_range: assert property (@(posedge clock) disable iff (!rst_n)
		plot |-> (plot_x >= coord_x_t'(1) && plot_x <= coord_x_t'(`IMAGE_W - 2)
			&& plot_y >= coord_y_t'(1) && plot_y <= coord_y_t'(`IMAGE_H - 2)))
		else $error("plot position outside the image interior");

endmodule

bind motion_top motion_asserts asserts_i (
	.clock          (clock),
	.rst_n          (rst_n),
	.plot           (plot),
	.plot_x         (plot_x),
	.plot_y         (plot_y),
	.centroid_valid (centroid_valid)
);

/* src/motion_top.sv */
`timescale 1ns/1ps

module motion_top (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 pixel_en,
	input  motion_pkg::coord_x_t pixel_x,
	input  motion_pkg::coord_y_t pixel_y,
	input  motion_pkg::colour_t  pixel_colour,
	input  logic                 vsync_n,
	output logic                 plot,
	output motion_pkg::coord_x_t plot_x,
	output motion_pkg::coord_y_t plot_y,
	output logic                 plot_colour,
	output logic                 centroid_valid,
	output motion_pkg::coord_x_t centroid_x,
	output motion_pkg::coord_y_t centroid_y
);
	import motion_pkg::*;

	pixel_addr_t prev_rd_addr;
	colour_t     prev_rd_data;
	logic        prev_wr_en;
	pixel_addr_t prev_wr_addr;
	colour_t     prev_wr_data;
	logic        diff_wr_en;
	pixel_addr_t diff_wr_addr;
	logic        diff_wr_data;
	pixel_addr_t diff_rd_addr;
	logic        diff_rd_data;

	coord_x_t    scan_x;
	coord_y_t    scan_y;
	logic        frame_last;
	logic        fetch;
	logic [1:0]  fetch_row;
	logic        shift;
	logic        step;
	logic        clear_scan;
	logic        calc_start;
	logic        clear_totals;
	total_t      x_total;
	total_t      y_total;
	count_t      diff_count;

	difference_engine diff_eng_i (
		.clock        (clock),
		.rst_n        (rst_n),
		.pixel_en     (pixel_en),
		.pixel_x      (pixel_x),
		.pixel_y      (pixel_y),
		.pixel_colour (pixel_colour),
		.prev_rd_data (prev_rd_data),
		.prev_rd_addr (prev_rd_addr),
		.prev_wr_en   (prev_wr_en),
		.prev_wr_addr (prev_wr_addr),
		.prev_wr_data (prev_wr_data),
		.diff_wr_en   (diff_wr_en),
		.diff_wr_addr (diff_wr_addr),
		.diff_wr_data (diff_wr_data)
	);

	frame_ram #(.payload_t(colour_t)) prev_ram (
		.clock   (clock),
		.wr_en   (prev_wr_en),
		.wr_addr (prev_wr_addr),
		.wr_data (prev_wr_data),
		.rd_addr (prev_rd_addr),
		.rd_data (prev_rd_data)
	);

	frame_ram #(.payload_t(logic)) diff_ram (
		.clock   (clock),
		.wr_en   (diff_wr_en),
		.wr_addr (diff_wr_addr),
		.wr_data (diff_wr_data),
		.rd_addr (diff_rd_addr),
		.rd_data (diff_rd_data)
	);

	scan_counter scan_cnt_i (
		.clock      (clock),
		.rst_n      (rst_n),
		.clear      (clear_scan),
		.step       (step),
		.scan_x     (scan_x),
		.scan_y     (scan_y),
		.frame_last (frame_last)
	);

	scan_fsm scan_fsm_i (
		.clock        (clock),
		.rst_n        (rst_n),
		.vsync_n      (vsync_n),
		.frame_last   (frame_last),
		.diff_count   (diff_count),
		.calc_done    (centroid_valid),
		.fetch        (fetch),
		.fetch_row    (fetch_row),
		.shift        (shift),
		.step         (step),
		.clear_scan   (clear_scan),
		.calc_start   (calc_start),
		.clear_totals (clear_totals)
	);

	window_filter win_filt_i (
		.clock        (clock),
		.rst_n        (rst_n),
		.fetch        (fetch),
		.fetch_row    (fetch_row),
		.shift        (shift),
		.clear_totals (clear_totals),
		.scan_x       (scan_x),
		.scan_y       (scan_y),
		.diff_rd_data (diff_rd_data),
		.diff_rd_addr (diff_rd_addr),
		.plot         (plot),
		.plot_x       (plot_x),
		.plot_y       (plot_y),
		.plot_colour  (plot_colour),
		.x_total      (x_total),
		.y_total      (y_total),
		.diff_count   (diff_count)
	);

	centroid_calc centroid_i (
		.clock      (clock),
		.rst_n      (rst_n),
		.calc_start (calc_start),
		.x_total    (x_total),
		.y_total    (y_total),
		.diff_count (diff_count),
		.calc_done  (centroid_valid),
		.centroid_x (centroid_x),
		.centroid_y (centroid_y)
	);

endmodule

/* src/centroid_calc.sv */
`timescale 1ns/1ps
`include "motion_config.svh"

module centroid_calc (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 calc_start,
	input  motion_pkg::total_t   x_total,
	input  motion_pkg::total_t   y_total,
	input  motion_pkg::count_t   diff_count,
	output logic                 calc_done,
	output motion_pkg::coord_x_t centroid_x,
	output motion_pkg::coord_y_t centroid_y
);
	import motion_pkg::*;

	logic     mean_valid;
	coord_x_t mean_x;
	coord_y_t mean_y;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			mean_valid <= 1'b0;
			calc_done  <= 1'b0;
		end else begin
			mean_valid <= calc_start;
			calc_done  <= mean_valid;
		end
	end

	// count is above threshold here, never zero
	always_ff @(posedge clock) begin
		if (calc_start) begin
			mean_x <= coord_x_t'(x_total / total_t'(diff_count));
			mean_y <= coord_y_t'(y_total / total_t'(diff_count));
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			centroid_x <= '0;
			centroid_y <= '0;
		end else if (mean_valid) begin
			centroid_x <= coord_x_t'((centroid_x * `BLEND_OLD + mean_x * `BLEND_NEW)
				>> `BLEND_SHIFT);
			centroid_y <= coord_y_t'((centroid_y * `BLEND_OLD + mean_y * `BLEND_NEW)
				>> `BLEND_SHIFT);
		end
	end

endmodule

/* src/window_filter.sv */
`timescale 1ns/1ps
`include "motion_config.svh"

module window_filter (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    fetch,
	input  logic [1:0]              fetch_row,
	input  logic                    shift,
	input  logic                    clear_totals,
	input  motion_pkg::coord_x_t    scan_x,
	input  motion_pkg::coord_y_t    scan_y,
	input  logic                    diff_rd_data,
	output motion_pkg::pixel_addr_t diff_rd_addr,
	output logic                    plot,
	output motion_pkg::coord_x_t    plot_x,
	output motion_pkg::coord_y_t    plot_y,
	output logic                    plot_colour,
	output motion_pkg::total_t      x_total,
	output motion_pkg::total_t      y_total,
	output motion_pkg::count_t      diff_count
);
	import motion_pkg::*;

	logic       fetch_d;
	logic [1:0] row_d;
	logic [2:0] new_col;      // bit n is row y+n
	logic [2:0] win [0:2];    // oldest column first

	assign diff_rd_addr = pixel_addr_t'((scan_y + fetch_row) * `IMAGE_W + scan_x);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			fetch_d <= 1'b0;
			plot    <= 1'b0;
		end else begin
			fetch_d <= fetch;
			plot    <= shift && (scan_x >= coord_x_t'(2)); // need three columns
		end
	end

	always_ff @(posedge clock) begin
		row_d <= fetch_row;
		if (fetch_d) begin
			new_col[row_d] <= diff_rd_data;
		end
		if (shift) begin
			win[0] <= win[1];
			win[1] <= win[2];
			win[2] <= new_col;
			plot_x <= scan_x - 1'b1; // centre of the window
			plot_y <= scan_y + 1'b1;
		end
	end

	// erosion
	assign plot_colour = &{win[0], win[1], win[2]};

	always_ff @(posedge clock) begin
		if (!rst_n || clear_totals) begin
			x_total    <= '0;
			y_total    <= '0;
			diff_count <= '0;
		end else if (plot && plot_colour) begin
			x_total    <= x_total + total_t'(plot_x);
			y_total    <= y_total + total_t'(plot_y);
			diff_count <= diff_count + 1'b1;
		end
	end

endmodule

/* src/scan_fsm.sv */
`timescale 1ns/1ps
`include "motion_config.svh"

module scan_fsm (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               vsync_n,
	input  logic               frame_last,
	input  motion_pkg::count_t diff_count,
	input  logic               calc_done,
	output logic               fetch,
	output logic [1:0]         fetch_row,
	output logic               shift,
	output logic               step,
	output logic               clear_scan,
	output logic               calc_start,
	output logic               clear_totals
);
	import motion_pkg::*;

	scan_state_t state;
	scan_state_t state_next;
	logic        over_threshold;

	assign over_threshold = (diff_count >= count_t'(`DIFF_THRESHOLD));

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= WAIT_FRAME;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			WAIT_FRAME: if (!vsync_n) state_next = READ_TOP;
			READ_TOP:   state_next = READ_MID;
			READ_MID:   state_next = READ_BOT;
			READ_BOT:   state_next = SETTLE;
			SETTLE:     state_next = EMIT;
			EMIT:       state_next = frame_last ? FLUSH : READ_TOP;
			FLUSH:      state_next = DECIDE;
			DECIDE:     state_next = over_threshold ? CALC : WAIT_FRAME;
			CALC:       if (calc_done) state_next = WAIT_FRAME;
			default:    state_next = WAIT_FRAME;
		endcase
	end

	always_comb begin
		case (state)
			READ_MID: fetch_row = 2'd1;
			READ_BOT: fetch_row = 2'd2;
			default:  fetch_row = 2'd0;
		endcase
	end

	assign fetch = (state == READ_TOP) || (state == READ_MID) || (state == READ_BOT);
	assign shift = (state == EMIT);
	assign step  = (state == EMIT);

	// counter sits at the origin between scans
	assign clear_scan = (state == WAIT_FRAME);

	assign calc_start = (state == DECIDE) && over_threshold;

	// drop the sums once they are used, or when too few pixels moved
	assign clear_totals = ((state == DECIDE) && !over_threshold)
		|| ((state == CALC) && calc_done);

endmodule

/* src/scan_counter.sv */
`timescale 1ns/1ps
`include "motion_config.svh"

module scan_counter (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 clear,
	input  logic                 step,
	output motion_pkg::coord_x_t scan_x,
	output motion_pkg::coord_y_t scan_y,
	output logic                 frame_last
);
	import motion_pkg::*;

	logic x_end;
	logic y_end;

	assign x_end = (scan_x == coord_x_t'(`IMAGE_W - 1));
	assign y_end = (scan_y == coord_y_t'(`IMAGE_H - 3)); // window top row limit
	assign frame_last = x_end && y_end;

	always_ff @(posedge clock) begin
		if (!rst_n || clear) begin
			scan_x <= '0;
			scan_y <= '0;
		end else if (step) begin
			if (x_end) begin
				scan_x <= '0;
				scan_y <= y_end ? '0 : scan_y + 1'b1;
			end else begin
				scan_x <= scan_x + 1'b1;
			end
		end
	end

endmodule

/* src/difference_engine.sv */
`timescale 1ns/1ps
`include "motion_config.svh"

module difference_engine (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    pixel_en,
	input  motion_pkg::coord_x_t    pixel_x,
	input  motion_pkg::coord_y_t    pixel_y,
	input  motion_pkg::colour_t     pixel_colour,
	input  motion_pkg::colour_t     prev_rd_data,
	output motion_pkg::pixel_addr_t prev_rd_addr,
	output logic                    prev_wr_en,
	output motion_pkg::pixel_addr_t prev_wr_addr,
	output motion_pkg::colour_t     prev_wr_data,
	output logic                    diff_wr_en,
	output motion_pkg::pixel_addr_t diff_wr_addr,
	output logic                    diff_wr_data
);
	import motion_pkg::*;

	logic        s1_valid;
	logic        s2_valid;
	pixel_addr_t s1_addr;
	pixel_addr_t s2_addr;
	colour_t     s1_colour;
	colour_t     s2_colour;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= pixel_en;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (pixel_en) begin
			s1_addr   <= pixel_addr_t'(pixel_y * `IMAGE_W + pixel_x);
			s1_colour <= pixel_colour;
		end
		if (s1_valid) begin
			s2_addr   <= s1_addr;
			s2_colour <= s1_colour;
		end
	end

	// stage 1 reads the old colour
	assign prev_rd_addr = s1_addr;

	// stage 2 has it back, write both maps
	assign prev_wr_en   = s2_valid;
	assign prev_wr_addr = s2_addr;
	assign prev_wr_data = s2_colour;
	assign diff_wr_en   = s2_valid;
	assign diff_wr_addr = s2_addr;
	assign diff_wr_data = (prev_rd_data != s2_colour);

endmodule

/* src/frame_ram.sv */
`timescale 1ns/1ps
`include "motion_config.svh"

module frame_ram #(
	parameter type payload_t = logic
) (
	input  logic                                     clock,
	input  logic                                     wr_en,
	input  logic [$clog2(`IMAGE_W * `IMAGE_H)-1:0]   wr_addr,
	input  payload_t                                 wr_data,
	input  logic [$clog2(`IMAGE_W * `IMAGE_H)-1:0]   rd_addr,
	output payload_t                                 rd_data
);

	payload_t mem [`IMAGE_W * `IMAGE_H];

	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr]; // one cycle read latency
	end

endmodule

/* src/motion_pkg.sv */
package motion_pkg;

	typedef logic [8:0]  coord_x_t;
	typedef logic [7:0]  coord_y_t;
	typedef logic [16:0] pixel_addr_t;  // y * W + x
	typedef logic [2:0]  colour_t;
	typedef logic [23:0] total_t;
	typedef logic [16:0] count_t;

	typedef enum logic [3:0] {
		WAIT_FRAME,
		READ_TOP,
		READ_MID,
		READ_BOT,
		SETTLE,    // last column bit lands
		EMIT,
		FLUSH,     // final accumulate
		DECIDE,
		CALC
	} scan_state_t;

endpackage

/* src/motion_config.svh */
`ifndef MOTION_CONFIG_SVH
`define MOTION_CONFIG_SVH

// image geometry
`define IMAGE_W 320
`define IMAGE_H 240

// minimum eroded pixel count before the centroid moves
`define DIFF_THRESHOLD 400

// new centroid = (old * BLEND_OLD + mean * BLEND_NEW) >> BLEND_SHIFT
`define BLEND_OLD 10
`define BLEND_NEW 6
`define BLEND_SHIFT 4

`endif
